// ==== Bender.yml ====
package:
  name: exu_alu

sources:
  - files:
      - design/exu_alu_pkg.sv
      - design/exu_alu_decode.sv
      - design/exu_alu_rglr.sv
      - design/exu_alu_dpath.sv
      - design/exu_alu_wbck.sv
      - design/exu_alu_top.sv
  - target: test
    include_dirs:
      - dv
    files:
      - dv/tb_exu_alu_top.sv

// ==== design/exu_alu_decode.sv ====
// RV32I ALU decoder producing the info word, immediate and rd index
`timescale 1ns/1ps
`default_nettype none

module exu_alu_decode import exu_alu_pkg::*; (
  input  wire [31:0]     instr,
  input  wire [xlen-1:0] rs1,
  input  wire [xlen-1:0] rs2,
  input  wire [xlen-1:0] pc,
  output alu_in_t        dec,
  output logic [4:0]     rd,
  output logic           ilgl
);

  logic [6:0]      opc;
  logic [2:0]      f3;
  logic [6:0]      f7;
  logic            f7_zero;    // funct7 all zero
  logic            f7_alt;     // funct7 of sub/sra
  logic [xlen-1:0] imm_i;
  logic [xlen-1:0] imm_u;
  logic            bad;
  alu_info_t       info;

  //////////////////////////////////////////////////////////////////////
  // Field extraction

  assign opc     = instr[6:0];
  assign f3      = instr[14:12];
  assign f7      = instr[31:25];
  assign f7_zero = (f7 == 7'b000_0000);
  assign f7_alt  = (f7 == 7'b010_0000);
  assign imm_i   = {{20{instr[31]}}, instr[31:20]};  // Shamt sits in [4:0]
  assign imm_u   = {instr[31:12], 12'b0};
  assign rd      = instr[11:7];

  //////////////////////////////////////////////////////////////////////
  // Info word

  always_comb begin
    info     = '0;
    info.grp = grp_alu;
    bad      = 1'b0;
    case (opc)
      opc_op, opc_opimm: begin
        info.op2imm = (opc == opc_opimm);
        case (f3)
          3'b000: begin
            info.sub = (opc == opc_op) & f7_alt;    // No subi
            info.add = ~info.sub;
          end
          3'b001: info.sll  = 1'b1;
          3'b010: info.slt  = 1'b1;
          3'b011: info.sltu = 1'b1;
          3'b100: info.bxor = 1'b1;
          3'b101: begin
            info.sra = f7_alt;
            info.srl = ~f7_alt;
          end
          3'b110: info.bor  = 1'b1;
          default: info.band = 1'b1;
        endcase
        // funct7 legality
        if (opc == opc_op) begin
          bad = ~(f7_zero | (f7_alt & ((f3 == 3'b000) | (f3 == 3'b101))));
        end else begin
          bad = ((f3 == 3'b001) & ~f7_zero) | ((f3 == 3'b101) & ~(f7_zero | f7_alt));
        end
      end
      opc_lui: begin
        info.lui    = 1'b1;
        info.op2imm = 1'b1;
      end
      opc_auipc: begin
        info.add    = 1'b1;   // pc + U-imm
        info.op1pc  = 1'b1;
        info.op2imm = 1'b1;
      end
      default: bad = 1'b1;    // Not an ALU opcode
    endcase

    if (bad) begin
      info     = '0;          // Datapath returns zero
      info.grp = grp_alu;
      info.nop = 1'b1;
    end else if (instr == instr_nop) begin
      info.nop = 1'b1;        // Keeps add, masked later
    end
  end

  assign ilgl = bad;

  assign dec = '{
    rs1:  rs1,
    rs2:  rs2,
    imm:  (opc == opc_lui || opc == opc_auipc) ? imm_u : imm_i,
    pc:   pc,
    info: info
  };

endmodule

`default_nettype wire

// ==== design/exu_alu_dpath.sv ====
// Shared ALU datapath for add, compare, logic and shift requests
`timescale 1ns/1ps
`default_nettype none

module exu_alu_dpath import exu_alu_pkg::*; (
  input  wire alu_req_t   req,
  output logic [xlen-1:0] res
);

  alu_op_t         op;
  logic [xlen-1:0] op1;
  logic [xlen-1:0] op2;
  logic            do_sub;     // Adder in subtract mode
  logic [xlen-1:0] adder_in2;
  logic [xlen:0]   sum_ext;    // Carry out on top
  logic [xlen-1:0] sum;
  logic            lt_s;
  logic            lt_u;
  logic [4:0]      shamt;
  logic [xlen-1:0] sll_res;
  logic [xlen-1:0] srl_res;
  logic [xlen-1:0] sra_res;

  assign op  = req.op;
  assign op1 = req.op1;
  assign op2 = req.op2;

  //////////////////////////////////////////////////////////////////////
  // Shared adder

  // Compares reuse the subtractor
  assign do_sub    = op.sub | op.slt | op.sltu;
  assign adder_in2 = do_sub ? ~op2 : op2;
  assign sum_ext   = {1'b0, op1} + {1'b0, adder_in2} + {{xlen{1'b0}}, do_sub};
  assign sum       = sum_ext[xlen-1:0];

  assign lt_u = ~sum_ext[xlen];          // Borrow out
  // Signs differ means op1 sign decides
  assign lt_s = (op1[xlen-1] != op2[xlen-1]) ? op1[xlen-1] : sum[xlen-1];

  //////////////////////////////////////////////////////////////////////
  // Shifter

  assign shamt   = op2[4:0];             // Upper bits ignored
  assign sll_res = op1 << shamt;
  assign srl_res = op1 >> shamt;
  assign sra_res = $signed(op1) >>> shamt;  // Sign fill

  //////////////////////////////////////////////////////////////////////
  // AND-OR result mux, zero when idle

  assign res = ({xlen{op.add | op.sub}} & sum)
             | ({xlen{op.slt}}  & {{(xlen-1){1'b0}}, lt_s})
             | ({xlen{op.sltu}} & {{(xlen-1){1'b0}}, lt_u})
             | ({xlen{op.bxor}} & (op1 ^ op2))
             | ({xlen{op.bor}}  & (op1 | op2))
             | ({xlen{op.band}} & (op1 & op2))
             | ({xlen{op.sll}}  & sll_res)
             | ({xlen{op.srl}}  & srl_res)
             | ({xlen{op.sra}}  & sra_res)
             | ({xlen{op.lui}}  & op2);      // U-imm straight out

endmodule

`default_nettype wire

// ==== design/exu_alu_pkg.sv ====
// Shared width, opcodes and payload structs of the RV32I integer ALU slice
`default_nettype none

package exu_alu_pkg;

  //////////////////////////////////////////////////////////////////////
  // Widths and encodings

  localparam int xlen = 32;                       // RV32 data width

  localparam logic [1:0] grp_alu = 2'b00;         // Regular ALU group

  // Major opcodes handled by this slice
  localparam logic [6:0] opc_op    = 7'b0110011;  // Reg-reg
  localparam logic [6:0] opc_opimm = 7'b0010011;  // Reg-imm
  localparam logic [6:0] opc_lui   = 7'b0110111;
  localparam logic [6:0] opc_auipc = 7'b0010111;

  localparam logic [31:0] instr_nop = 32'h0000_0013;  // addi x0,x0,0

  //////////////////////////////////////////////////////////////////////
  // Decode info word, 16 bits, MSB first

  typedef struct packed {
    logic       nop;     // 15 Canonical NOP or illegal
    logic       op1pc;   // 14 PC as first operand
    logic       op2imm;  // 13 Immediate as second operand
    logic       lui;     // 12
    logic       sra;     // 11
    logic       srl;     // 10
    logic       sll;     // 9
    logic       band;    // 8
    logic       bor;     // 7
    logic       bxor;    // 6
    logic       sltu;    // 5
    logic       slt;     // 4
    logic       sub;     // 3
    logic       add;     // 2
    logic [1:0] grp;     // 1:0 Instruction group
  } alu_info_t;

  // Operand bundle from decode
  typedef struct packed {
    logic [xlen-1:0] rs1;
    logic [xlen-1:0] rs2;
    logic [xlen-1:0] imm;
    logic [xlen-1:0] pc;
    alu_info_t       info;
  } alu_in_t;

  // One-hot request flags to the shared datapath
  typedef struct packed {
    logic lui;
    logic sra;
    logic srl;
    logic sll;
    logic band;
    logic bor;
    logic bxor;
    logic sltu;
    logic slt;
    logic sub;
    logic add;
  } alu_op_t;

  typedef struct packed {
    alu_op_t         op;
    logic [xlen-1:0] op1;
    logic [xlen-1:0] op2;
  } alu_req_t;

  // Write-back payload
  typedef struct packed {
    logic [xlen-1:0] res;
    logic [4:0]      rd;
    logic            ilgl;    // Not an ALU instruction
  } wbck_t;

endpackage

`default_nettype wire

// ==== design/exu_alu_rglr.sv ====
// Regular ALU unit that selects operands and issues shared datapath requests
`timescale 1ns/1ps
`default_nettype none

module exu_alu_rglr import exu_alu_pkg::*; (
  input  wire             clk,
  input  wire             rst_n,
  // Issue side
  input  wire             i_valid,
  output logic            i_ready,
  input  wire alu_in_t    i_dat,
  // Write-back side
  output logic            o_valid,
  input  wire             o_ready,
  output logic [xlen-1:0] o_wdat,
  // Shared datapath
  output alu_req_t        req,
  input  wire [xlen-1:0]  res
);

  alu_info_t info;

  assign info = i_dat.info;

  //////////////////////////////////////////////////////////////////////
  // Operand select and request flags

  always_comb begin
    req.op1      = info.op1pc  ? i_dat.pc  : i_dat.rs1;   // AUIPC uses pc
    req.op2      = info.op2imm ? i_dat.imm : i_dat.rs2;
    // NOP decodes as addi, so add is dropped here
    req.op.add   = info.add & ~info.nop;
    req.op.sub   = info.sub;
    req.op.slt   = info.slt;
    req.op.sltu  = info.sltu;
    req.op.bxor  = info.bxor;
    req.op.bor   = info.bor;
    req.op.band  = info.band;
    req.op.sll   = info.sll;
    req.op.srl   = info.srl;
    req.op.sra   = info.sra;
    req.op.lui   = info.lui;
  end

  // Handshake straight through
  assign o_valid = i_valid;
  assign i_ready = o_ready;

  assign o_wdat  = res;     // Datapath result to write-back

  //////////////////////////////////////////////////////////////////////
  // Checks

  // Decoder hands over at most one datapath operation
  a_req_onehot: assert property (@(posedge clk) disable iff (!rst_n)
    i_valid |-> $onehot0(req.op));

endmodule

`default_nettype wire

// ==== design/exu_alu_top.sv ====
// Integer ALU slice top linking decode, regular unit, datapath and write-back
`timescale 1ns/1ps
`default_nettype none

module exu_alu_top import exu_alu_pkg::*; (
  input  wire            clk,
  input  wire            rst_n,
  input  wire            i_valid,
  output logic           i_ready,
  input  wire [31:0]     i_instr,
  input  wire [xlen-1:0] i_rs1,
  input  wire [xlen-1:0] i_rs2,
  input  wire [xlen-1:0] i_pc,
  output logic           o_valid,
  input  wire            o_ready,
  output wbck_t          o_wbck
);

  alu_in_t         dec;
  logic [4:0]      rd;
  logic            ilgl;
  logic            rglr_valid;   // Regular unit to write-back
  logic            rglr_ready;
  logic [xlen-1:0] wdat;
  alu_req_t        req;
  logic [xlen-1:0] res;
  wbck_t           wb_in;

  exu_alu_decode u_decode (
    .instr (i_instr),
    .rs1   (i_rs1),
    .rs2   (i_rs2),
    .pc    (i_pc),
    .dec   (dec),
    .rd    (rd),
    .ilgl  (ilgl)
  );

  exu_alu_rglr u_rglr (
    .clk     (clk),
    .rst_n   (rst_n),
    .i_valid (i_valid),
    .i_ready (i_ready),
    .i_dat   (dec),
    .o_valid (rglr_valid),
    .o_ready (rglr_ready),
    .o_wdat  (wdat),
    .req     (req),
    .res     (res)
  );

  exu_alu_dpath u_dpath (
    .req (req),
    .res (res)
  );

  // rd and ilgl bypass the regular unit
  assign wb_in = '{res: wdat, rd: rd, ilgl: ilgl};

  exu_alu_wbck u_wbck (
    .clk     (clk),
    .rst_n   (rst_n),
    .i_valid (rglr_valid),
    .i_ready (rglr_ready),
    .i_dat   (wb_in),
    .o_valid (o_valid),
    .o_ready (o_ready),
    .o_dat   (o_wbck)
  );

endmodule

`default_nettype wire

// ==== design/exu_alu_wbck.sv ====
// One-entry write-back register with a valid/ready handshake
`timescale 1ns/1ps
`default_nettype none

module exu_alu_wbck import exu_alu_pkg::*; (
  input  wire          clk,
  input  wire          rst_n,
  input  wire          i_valid,
  output logic         i_ready,
  input  wire wbck_t   i_dat,
  output logic         o_valid,
  input  wire          o_ready,
  output wbck_t        o_dat
);

  logic  full;     // Entry occupied
  logic  load;     // Upstream handshake
  wbck_t dat_q;

  // Accept when empty or draining this cycle
  assign i_ready = ~full | o_ready;
  assign load    = i_valid & i_ready;

  //////////////////////////////////////////////////////////////////////
  // Entry state

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      full <= 1'b0;
    end else if (load) begin
      full <= 1'b1;          // Refill wins over drain
    end else if (o_ready) begin
      full <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      dat_q <= i_dat;
    end
  end

  assign o_valid = full;
  assign o_dat   = dat_q;

  //////////////////////////////////////////////////////////////////////
  // Checks

  // Stalled output holds
  a_hold: assert property (@(posedge clk) disable iff (!rst_n)
    o_valid && !o_ready |=> o_valid && $stable(o_dat));

  // Nothing pending after reset
  a_rst_empty: assert property (@(posedge clk)
    !rst_n |=> !o_valid);

endmodule

`default_nettype wire

// ==== dv/tb_exu_alu_ref.svh ====
// Reference model giving the expected write-back of one RV32I ALU instruction
`ifndef tb_exu_alu_ref_svh
`define tb_exu_alu_ref_svh

// Expected result, rd and illegal flag from the ISA rules
function automatic wbck_t ref_wbck(input logic [31:0] instr, input logic [31:0] rs1,
                                   input logic [31:0] rs2, input logic [31:0] pc);
  logic [6:0]  opc;
  logic [2:0]  f3;
  logic [6:0]  f7;
  logic [31:0] b;
  logic [31:0] r;
  logic        ok;
  opc = instr[6:0];
  f3  = instr[14:12];
  f7  = instr[31:25];
  b   = (opc == 7'h33) ? rs2 : {{20{instr[31]}}, instr[31:20]};  // Reg or I-imm
  r   = 32'h0;
  ok  = 1'b1;
  case (opc)
    7'h37: r = {instr[31:12], 12'h000};          // LUI
    7'h17: r = pc + {instr[31:12], 12'h000};     // AUIPC
    7'h33, 7'h13: begin
      if (opc == 7'h33) begin
        ok = (f7 == 7'h00) || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5));
      end else begin
        ok = !(f3 == 3'd1 && f7 != 7'h00) && !(f3 == 3'd5 && f7 != 7'h00 && f7 != 7'h20);
      end
      case (f3)
        3'd0: r = (opc == 7'h33 && f7 == 7'h20) ? rs1 - b : rs1 + b;
        3'd1: r = rs1 << b[4:0];
        3'd2: r = {31'h0, $signed(rs1) < $signed(b)};
        3'd3: r = {31'h0, rs1 < b};
        3'd4: r = rs1 ^ b;
        3'd5: begin
          if (f7 == 7'h20) begin
            r = $signed(rs1) >>> b[4:0];         // Sign fill
          end else begin
            r = rs1 >> b[4:0];
          end
        end
        3'd6: r = rs1 | b;
        default: r = rs1 & b;
      endcase
    end
    default: ok = 1'b0;                          // Outside this slice
  endcase
  if (!ok || instr == 32'h0000_0013) r = 32'h0;  // Illegal and NOP write zero
  return '{res: r, rd: instr[11:7], ilgl: !ok};
endfunction

`endif

// ==== dv/tb_exu_alu_top.sv ====
// Testbench for the integer ALU slice with random stimulus and a scoreboard
`timescale 1ns/1ps
`default_nettype none

module tb_exu_alu_top import exu_alu_pkg::*; ();

  localparam int n_items = 2000;
  localparam int clk_per = 40;

  logic        clk = 1'b0;
  logic        rst_n;
  logic        i_valid;
  logic        i_ready;
  logic [31:0] i_instr;
  logic [31:0] i_rs1;
  logic [31:0] i_rs2;
  logic [31:0] i_pc;
  logic        o_valid;
  logic        o_ready;
  wbck_t       o_wbck;

  integer seed      = 32'hb930ce69;
  int     errors    = 0;
  int     checks    = 0;
  wbck_t  exp_q[$];                   // Scoreboard, oldest first
  logic   prev_acc  = 1'b0;           // Accepted at last edge
  logic   prev_stall = 1'b0;          // Output stalled at last edge
  logic   rst_q     = 1'b0;
  wbck_t  prev_wbck;

  `include "tb_exu_alu_ref.svh"

  exu_alu_top UUT (
    .clk (clk), .rst_n (rst_n),
    .i_valid (i_valid), .i_ready (i_ready), .i_instr (i_instr),
    .i_rs1 (i_rs1), .i_rs2 (i_rs2), .i_pc (i_pc),
    .o_valid (o_valid), .o_ready (o_ready), .o_wbck (o_wbck)
  );

  initial begin
    forever #(clk_per / 2) clk = ~clk;
  end

  //////////////////////////////////////////////////////////////////////
  // Stimulus helpers

  task automatic check_value(input string name, input logic [37:0] exp, input logic [37:0] act);
    checks++;
    assert (act === exp) else begin
      errors++;
      $display("** Error: %s expected %0h got %0h", name, exp, act);
    end
  endtask

  // Corner values weighted against plain random
  function automatic logic [31:0] pick_operand();
    logic [2:0] k;
    k = $random(seed);
    case (k)
      3'd0: return 32'h0000_0000;
      3'd1: return 32'h8000_0000;
      3'd2: return 32'h7fff_ffff;
      3'd3: return 32'hffff_ffff;
      3'd4: return 32'h0000_001f;
      default: return $random(seed);
    endcase
  endfunction

  function automatic logic [31:0] pick_instr();
    logic [31:0] r;
    logic [31:0] r2;
    logic [11:0] imm;
    logic [6:0]  bad_opc [4] = '{7'h03, 7'h23, 7'h63, 7'h73};  // Load, store, branch, system
    r   = $random(seed);
    r2  = $random(seed);
    imm = r2[11:0];
    if ((r[6:4] == 3'd1 || r[6:4] == 3'd5) && r2[23:21] != 3'd0) begin
      imm[11:5] = (r2[20] && r[6:4] == 3'd5) ? 7'h20 : 7'h00;  // Mostly legal shifts
    end
    case (r[3:0])
      4'd0, 4'd1, 4'd2, 4'd3: return {r[12] ? 7'h20 : 7'h00, r2[24:15], r[6:4], r[11:7], opc_op};
      4'd4, 4'd5, 4'd6, 4'd7: return {imm, r2[16:12], r[6:4], r[11:7], opc_opimm};
      4'd8, 4'd9:   return {r2[31:12], r[11:7], opc_lui};
      4'd10, 4'd11: return {r2[31:12], r[11:7], opc_auipc};
      4'd12:        return instr_nop;
      4'd13:        return {r2[31:25], r2[24:15], r[6:4], r[11:7], opc_op};  // Any funct7
      default:      return {r2[31:7], bad_opc[r2[1:0]]};
    endcase
  endfunction

  // One clock step, o_ready redrawn for back-pressure
  task automatic next_cycle();
    @(posedge clk);
    #2;
    o_ready = ({$random(seed)} % 4) != 0;
  endtask

  task automatic send_item();
    logic acc;
    i_valid = 1'b1;
    i_instr = pick_instr();
    i_rs1   = pick_operand();
    i_rs2   = pick_operand();
    i_pc    = {$random(seed)} & 32'hffff_fffc;
    acc     = 1'b0;
    while (!acc) begin
      @(negedge clk);
      acc = i_ready;                  // Held until the next edge
      next_cycle();
    end
    i_valid = 1'b0;
    if (({$random(seed)} % 4) == 0) next_cycle();  // Idle gap now and then
  endtask

  //////////////////////////////////////////////////////////////////////
  // Scoreboard and protocol checks, sampled mid-cycle

  always @(negedge clk) begin : monitor
    wbck_t exp_wb;
    if (!rst_n || !rst_q) check_value("o_valid", 38'h0, {37'h0, o_valid});
    if (prev_acc || prev_stall) check_value("o_valid", 38'h1, {37'h0, o_valid});
    if (prev_stall) check_value("o_wbck", prev_wbck, o_wbck);  // Held under stall
    if (o_valid && !o_ready) check_value("i_ready", 38'h0, {37'h0, i_ready});
    if (rst_n && o_valid && o_ready) begin
      if (exp_q.size() == 0) begin
        errors++;
        $display("A result left the DUT with no instruction pending");
      end else begin
        exp_wb = exp_q.pop_front();   // Drain before refill
        check_value("o_wbck.res", exp_wb.res, o_wbck.res);
        check_value("o_wbck.rd", exp_wb.rd, o_wbck.rd);
        check_value("o_wbck.ilgl", exp_wb.ilgl, o_wbck.ilgl);
      end
    end
    if (rst_n && i_valid && i_ready) exp_q.push_back(ref_wbck(i_instr, i_rs1, i_rs2, i_pc));
    prev_acc   = rst_n && i_valid && i_ready;
    prev_stall = o_valid && !o_ready;
    prev_wbck  = o_wbck;
    rst_q      = rst_n;
  end

  //////////////////////////////////////////////////////////////////////
  // Main sequence and watchdog

  initial begin
    rst_n   = 1'b0;
    i_valid = 1'b0;
    i_instr = 32'h0;
    i_rs1   = 32'h0;
    i_rs2   = 32'h0;
    i_pc    = 32'h0;
    o_ready = 1'b0;
    repeat (8) next_cycle();
    rst_n = 1'b1;
    for (int n = 0; n < n_items; n++) send_item();
    while (exp_q.size() != 0) next_cycle();      // Lost items end in the watchdog
    repeat (4) next_cycle();
    $display("Checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  initial begin
    #(n_items * clk_per * 4);
    $display("Watchdog expired with %0d results still expected", exp_q.size());
    $display("Test failed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== sim.f ====
+incdir+dv
design/exu_alu_pkg.sv
design/exu_alu_decode.sv
design/exu_alu_rglr.sv
design/exu_alu_dpath.sv
design/exu_alu_wbck.sv
design/exu_alu_top.sv
dv/tb_exu_alu_top.sv
